//--- logic/fm_mix_pkg.sv
/*
 * FM output mixer shared definitions
 * Slot schedule, data widths, configuration memory map and the
 * operator routing of each algorithm class
 */
package fm_mix_pkg;

    localparam int num_slots = 24;      // 6 channels x 4 operators
    localparam int num_chans = 6;
    localparam int op_w      = 14;      // Operator result
    localparam int snd_w     = 16;      // Sample / output width
    localparam int cfg_aw    = 5;       // Config word address
    localparam int cfg_dw    = 16;

    // Config memory map, word addresses
    localparam int slot_level_base = 0;  // 24 level words, pos*4 + op
    localparam int chan_cfg_base   = 24; // 6 channel words
    localparam int chan_alg_lsb    = 0;  // Channel word bits 2:0
    localparam int chan_rl_lsb     = 3;  // Bit 4 left, bit 3 right

    // Channels whose operator 0 slot carries ADPCM
    localparam logic [2:0] adpcm_a_ch = 3'd2;
    localparam logic [2:0] adpcm_b_ch = 3'd6;

    // Operators summed to output, bit n for operator n
    localparam logic [3:0] route_alg_0_3 = 4'b1000;
    localparam logic [3:0] route_alg_4   = 4'b1010;
    localparam logic [3:0] route_alg_5_6 = 4'b1110;
    localparam logic [3:0] route_alg_7   = 4'b1111;

    // Channel code 0,1,2,4,5,6 to position 0..5
    function automatic logic [2:0] ch_pos(input logic [2:0] ch);
        return (ch > 3'd2) ? ch - 3'd1 : ch;
    endfunction

endpackage

//--- logic/apb_cfg_slave.sv
/*
 * APB slave for the mixer configuration memory
 * Turns access phases into memory requests, waits for the grant
 * and, on reads, for the returned word
 */
module apb_cfg_slave
    import fm_mix_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [6:0]        paddr,
    input  logic [cfg_dw-1:0] pwdata,
    output logic [cfg_dw-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              bus_gnt,
    input  logic [cfg_dw-1:0] bus_rdata,
    output logic              bus_req,
    output logic              bus_we,
    output logic [cfg_aw-1:0] bus_addr,
    output logic [cfg_dw-1:0] bus_wdata
);

    typedef enum logic {
        st_gnt,     // Waiting for the arbiter
        st_rdata    // Granted read, word arrives now
    } state_t;

    state_t state;

    // Request only once per transfer, dropped after the grant
    assign bus_req   = psel & penable & (state == st_gnt);
    assign bus_we    = pwrite;
    assign bus_addr  = paddr[6:2];      // Byte to word address
    assign bus_wdata = pwdata;

    // Writes end on the grant, reads one cycle later
    assign pready  = (state == st_rdata) | (bus_gnt & bus_we);
    assign prdata  = bus_rdata;
    assign pslverr = 1'b0;              // No error responses

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_gnt;
        end else begin
            case (state)
                st_gnt:   if (bus_gnt && !bus_we) state <= st_rdata;
                st_rdata: state <= st_gnt;
                default:  state <= st_gnt;
            endcase
        end
    end

    // Master must hold the address through the wait states
    a_paddr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        psel && !pready |=> $stable(paddr))
        else $error("paddr changed during a pending APB transfer");

endmodule

//--- logic/cfg_mem_arbiter.sv
/*
 * Configuration memory with fixed priority arbitration
 * Slot reader always wins, the APB side is granted otherwise.
 * Read data comes back one cycle after the request
 */
module cfg_mem_arbiter
    import fm_mix_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              clk_en,
    input  logic              bus_req,
    input  logic              bus_we,
    input  logic [cfg_aw-1:0] bus_addr,
    input  logic [cfg_dw-1:0] bus_wdata,
    output logic              bus_gnt,
    output logic [cfg_dw-1:0] bus_rdata,
    input  logic              slot_req,
    input  logic [cfg_aw-1:0] slot_addr,
    output logic [cfg_dw-1:0] slot_rdata
);

    logic [cfg_dw-1:0] mem [num_slots + num_chans];  // Levels then channel words
    logic [cfg_dw-1:0] rd_q;                          // Shared read return

    assign bus_gnt = bus_req & ~slot_req;   // Reader has priority

    always_ff @(posedge clk) begin
        if (slot_req) begin
            rd_q <= mem[slot_addr];
        end else if (bus_gnt) begin
            if (bus_we) mem[bus_addr] <= bus_wdata;
            else        rd_q <= mem[bus_addr];
        end
    end

    // One return register, each side only samples after its own request
    assign slot_rdata = rd_q;
    assign bus_rdata  = rd_q;

    // Reader needs two free cycles after each slot step
    a_clk_en_gap: assert property (@(posedge clk) disable iff (!arst_n)
        clk_en |=> !clk_en [*2])
        else $error("clk_en high again within two cycles");

    // Both slot reads issued and returned before the next step
    a_slot_served: assert property (@(posedge clk) disable iff (!arst_n)
        clk_en |=> slot_req ##1 slot_req ##1 !slot_req)
        else $error("slot read pair not served after clk_en");

endmodule

//--- logic/slot_counter.sv
/*
 * Frame slot sequencer
 * Walks four operators per channel over channel codes 0,1,2,4,5,6,
 * one slot per clk_en, and flags the first slot of each frame
 */
module slot_counter (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       clk_en,
    output logic [2:0] cur_ch,
    output logic [1:0] cur_op,
    output logic       frame_start
);

    logic [2:0] next_ch;

    // Code 3 is skipped, 7 never reached
    always_comb begin
        case (cur_ch)
            3'd0:    next_ch = 3'd1;
            3'd1:    next_ch = 3'd2;
            3'd2:    next_ch = 3'd4;
            3'd4:    next_ch = 3'd5;
            3'd5:    next_ch = 3'd6;
            default: next_ch = 3'd0;    // Wrap after channel 6
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_ch <= 3'd0;
            cur_op <= 2'd0;
        end else if (clk_en) begin
            cur_op <= cur_op + 2'd1;    // Operator steps fastest
            if (cur_op == 2'd3) begin
                cur_ch <= next_ch;
            end
        end
    end

    assign frame_start = (cur_ch == 3'd0) && (cur_op == 2'd0);

endmodule

//--- logic/op_level_fetch.sv
/*
 * Per slot operator level and channel setting fetch
 * Reads the level word, then the channel word, after each clk_en and
 * presents them with the slot tags at the following clk_en
 */
module op_level_fetch
    import fm_mix_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clk_en,
    input  logic [2:0]             cur_ch,
    input  logic [1:0]             cur_op,
    input  logic                   frame_start,
    output logic                   slot_req,
    output logic [cfg_aw-1:0]      slot_addr,
    input  logic [cfg_dw-1:0]      slot_rdata,
    output logic signed [op_w-1:0] op_result,
    output logic [2:0]             alg,
    output logic [1:0]             rl,
    output logic [2:0]             tag_ch,
    output logic [1:0]             tag_op,
    output logic                   tag_zero
);

    logic [1:0]        ph;          // 1 level req, 2 chan req, 3 chan return
    logic [op_w-1:0]   level_q;     // Staged level of the slot being fetched
    logic [cfg_dw-1:0] chan_q;
    logic [cfg_dw-1:0] chan_word;

    assign slot_req  = (ph == 2'd1) || (ph == 2'd2);
    assign slot_addr = (ph == 2'd1) ? cfg_aw'(slot_level_base) + {ch_pos(cur_ch), cur_op}
                                    : cfg_aw'(chan_cfg_base) + cfg_aw'(ch_pos(cur_ch));

    // Channel word may land on the same edge as the next clk_en
    assign chan_word = (ph == 2'd3) ? slot_rdata : chan_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ph <= 2'd0;
        end else if (clk_en) begin
            ph <= 2'd1;                 // New slot, start fetching
        end else if (ph != 2'd0) begin
            ph <= ph + 2'd1;            // 3 wraps back to idle
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            level_q   <= '0;
            chan_q    <= '0;
            op_result <= '0;
            alg       <= '0;
            rl        <= '0;
            tag_ch    <= '0;
            tag_op    <= '0;
            tag_zero  <= 1'b0;
        end else begin
            if (ph == 2'd2) level_q <= slot_rdata[op_w-1:0];
            if (ph == 2'd3) chan_q  <= slot_rdata;
            if (clk_en) begin
                op_result <= level_q;   // Slot fetched since last clk_en
                alg       <= chan_word[chan_alg_lsb +: 3];
                rl        <= chan_word[chan_rl_lsb +: 2];
                tag_ch    <= cur_ch;    // Still the fetched slot here
                tag_op    <= cur_op;
                tag_zero  <= frame_start;
            end
        end
    end

endmodule

//--- logic/sample_acc.sv
/*
 * Saturating frame accumulator, one output side
 * Sums slot inputs over a frame and hands the 16-bit clamped total
 * to the held output at frame start
 */
module sample_acc
    import fm_mix_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clk_en,
    input  logic signed [snd_w-1:0] din,
    input  logic                    add_en,
    input  logic                    zero,
    output logic signed [snd_w-1:0] snd
);

    localparam int acc_w = snd_w + 2;   // 18-bit running sum

    logic signed [acc_w-1:0] sum;
    logic signed [acc_w-1:0] add_val;
    logic        [acc_w:0]   sum_ext;   // One guard bit for the add
    logic signed [acc_w-1:0] sum_nxt;
    logic signed [snd_w-1:0] sum_sat;

    always_comb begin
        add_val = add_en ? {{2{din[snd_w-1]}}, din} : '0;
        sum_ext = {sum[acc_w-1], sum} + {add_val[acc_w-1], add_val};
        // Clamp at 18 bits so full-scale frames cannot wrap
        if (sum_ext[acc_w] != sum_ext[acc_w-1])
            sum_nxt = sum_ext[acc_w] ? {1'b1, {(acc_w-1){1'b0}}} : {1'b0, {(acc_w-1){1'b1}}};
        else
            sum_nxt = sum_ext[acc_w-1:0];
        // Top three bits agree, value fits 16 bits
        if (&sum[acc_w-1:snd_w-1] || ~|sum[acc_w-1:snd_w-1])
            sum_sat = sum[snd_w-1:0];
        else
            sum_sat = sum[acc_w-1] ? {1'b1, {(snd_w-1){1'b0}}} : {1'b0, {(snd_w-1){1'b1}}};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                sum <= add_val;         // New frame starts with this slot
                snd <= sum_sat;         // Finished frame to output
            end else begin
                sum <= sum_nxt;
            end
        end
    end

endmodule

//--- logic/fm_out_acc.sv
/*
 * FM output stage with ADPCM substitution
 * Routes each presented slot by algorithm and panning into the left
 * and right frame accumulators
 */
module fm_out_acc
    import fm_mix_pkg::*;
#(
    parameter bit adpcm_mix = 1'b1
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clk_en,
    input  logic signed [op_w-1:0]  op_result,
    input  logic [2:0]              alg,
    input  logic [1:0]              rl,
    input  logic [2:0]              tag_ch,
    input  logic [1:0]              tag_op,
    input  logic                    tag_zero,
    input  logic signed [snd_w-1:0] adpcm_a_l,
    input  logic signed [snd_w-1:0] adpcm_a_r,
    input  logic signed [snd_w-1:0] adpcm_b_l,
    input  logic signed [snd_w-1:0] adpcm_b_r,
    output logic signed [snd_w-1:0] left,
    output logic signed [snd_w-1:0] right,
    output logic                    sample_valid
);

    logic [3:0]              route;
    logic                    sum_en;
    logic signed [snd_w-1:0] op_ext;
    logic signed [snd_w-1:0] acc_in_l, acc_in_r;
    logic                    acc_en_l, acc_en_r;

    always_comb begin
        case (alg)
            3'd4:       route = route_alg_4;
            3'd5, 3'd6: route = route_alg_5_6;
            3'd7:       route = route_alg_7;
            default:    route = route_alg_0_3;  // Carrier only
        endcase
    end

    assign sum_en = route[tag_op];
    assign op_ext = {{(snd_w - op_w){op_result[op_w-1]}}, op_result};

    // ADPCM slots drop the FM data, ignore alg and rl
    always_comb begin
        acc_in_l = op_ext;
        acc_in_r = op_ext;
        acc_en_l = sum_en & rl[1];
        acc_en_r = sum_en & rl[0];
        if (tag_op == 2'd0 && tag_ch == adpcm_a_ch) begin
            acc_in_l = adpcm_a_l <<< 3;
            acc_in_r = adpcm_a_r <<< 3;
            acc_en_l = adpcm_mix;
            acc_en_r = adpcm_mix;
        end else if (tag_op == 2'd0 && tag_ch == adpcm_b_ch) begin
            acc_in_l = adpcm_b_l >>> 3; // 16-bit samples, scaled down
            acc_in_r = adpcm_b_r >>> 3;
            acc_en_l = adpcm_mix;
            acc_en_r = adpcm_mix;
        end
    end

    sample_acc u_left (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .din    (acc_in_l),
        .add_en (acc_en_l),
        .zero   (tag_zero),
        .snd    (left)
    );

    sample_acc u_right (
        .clk    (clk),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .din    (acc_in_r),
        .add_en (acc_en_r),
        .zero   (tag_zero),
        .snd    (right)
    );

    // Pulse lines up with the new left/right
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) sample_valid <= 1'b0;
        else         sample_valid <= clk_en & tag_zero;
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(left) || $changed(right) |-> sample_valid)
        else $error("output changed without sample_valid");

endmodule

//--- logic/fm_mix_top.sv
/*
 * FM sound generator output mixer, top level
 * APB configuration port, slot sequencer, level fetch and the
 * left/right frame mixing path
 */
module fm_mix_top
    import fm_mix_pkg::*;
#(
    parameter bit adpcm_mix = 1'b1
) (
    input  logic                    clk,
    input  logic                    clk_en,
    input  logic                    arst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [6:0]              paddr,
    input  logic [cfg_dw-1:0]       pwdata,
    output logic [cfg_dw-1:0]       prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic signed [snd_w-1:0] adpcm_a_l,
    input  logic signed [snd_w-1:0] adpcm_a_r,
    input  logic signed [snd_w-1:0] adpcm_b_l,
    input  logic signed [snd_w-1:0] adpcm_b_r,
    output logic signed [snd_w-1:0] left,
    output logic signed [snd_w-1:0] right,
    output logic                    sample_valid
);

    // APB side of the memory
    logic              bus_req, bus_we, bus_gnt;
    logic [cfg_aw-1:0] bus_addr;
    logic [cfg_dw-1:0] bus_wdata, bus_rdata;
    // Slot reader side
    logic              slot_req;
    logic [cfg_aw-1:0] slot_addr;
    logic [cfg_dw-1:0] slot_rdata;
    // Sequencer and presented slot
    logic [2:0]             cur_ch, tag_ch, alg;
    logic [1:0]             cur_op, tag_op, rl;
    logic                   frame_start, tag_zero;
    logic signed [op_w-1:0] op_result;

    apb_cfg_slave u_apb (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .bus_gnt(bus_gnt), .bus_rdata(bus_rdata), .bus_req(bus_req),
        .bus_we(bus_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata)
    );

    cfg_mem_arbiter u_arb (
        .clk(clk), .arst_n(arst_n), .clk_en(clk_en),
        .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_gnt(bus_gnt), .bus_rdata(bus_rdata),
        .slot_req(slot_req), .slot_addr(slot_addr), .slot_rdata(slot_rdata)
    );

    slot_counter u_slot (
        .clk(clk), .arst_n(arst_n), .clk_en(clk_en),
        .cur_ch(cur_ch), .cur_op(cur_op), .frame_start(frame_start)
    );

    op_level_fetch u_fetch (
        .clk(clk), .arst_n(arst_n), .clk_en(clk_en),
        .cur_ch(cur_ch), .cur_op(cur_op), .frame_start(frame_start),
        .slot_req(slot_req), .slot_addr(slot_addr), .slot_rdata(slot_rdata),
        .op_result(op_result), .alg(alg), .rl(rl),
        .tag_ch(tag_ch), .tag_op(tag_op), .tag_zero(tag_zero)
    );

    fm_out_acc #(.adpcm_mix(adpcm_mix)) u_acc (
        .clk(clk), .arst_n(arst_n), .clk_en(clk_en),
        .op_result(op_result), .alg(alg), .rl(rl),
        .tag_ch(tag_ch), .tag_op(tag_op), .tag_zero(tag_zero),
        .adpcm_a_l(adpcm_a_l), .adpcm_a_r(adpcm_a_r),
        .adpcm_b_l(adpcm_b_l), .adpcm_b_r(adpcm_b_r),
        .left(left), .right(right), .sample_valid(sample_valid)
    );

endmodule

//--- verif/fm_mix_tb.sv
/*
 * Testbench for the FM output mixer
 * Drives APB configuration traffic and ADPCM samples, keeps a shadow
 * model of each frame's left/right sums and checks the sample outputs
 */
module fm_mix_tb
    import fm_mix_pkg::*;
();

    localparam int cycles_per_frame = num_slots * 4;    // clk_en one cycle in four
    // Reset, readback, routing, panning, ADPCM, saturation
    localparam int test_frames = 2 + 3 + 7 + 4 + 4 + 5;
    localparam int max_cycles  = test_frames * cycles_per_frame * 3 / 2;

    logic                    clk, clk_en, arst_n;
    logic                    psel, penable, pwrite;
    logic [6:0]              paddr;
    logic [15:0]             pwdata, prdata;
    logic                    pready, pslverr;
    logic signed [snd_w-1:0] adpcm_a_l, adpcm_a_r, adpcm_b_l, adpcm_b_r;
    logic signed [snd_w-1:0] left, right;
    logic                    sample_valid;

    int          errors, pulse_errors, checks, cycles, pulses, en_cnt, tests;
    logic        armed;            // Frame compare enabled
    int          exp_l, exp_r;
    logic [15:0] shadow [30];      // Config memory as software sees it

    fm_mix_top #(.adpcm_mix(1'b1)) fm_mix_top_i (
        .clk(clk), .clk_en(clk_en), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .adpcm_a_l(adpcm_a_l), .adpcm_a_r(adpcm_a_r),
        .adpcm_b_l(adpcm_b_l), .adpcm_b_r(adpcm_b_r),
        .left(left), .right(right), .sample_valid(sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Slot strobe starts after reset, 1 high then 3 low
    initial begin
        clk_en = 1'b0;
        @(posedge arst_n);
        forever begin
            repeat (3) begin
                @(posedge clk);
                #1 clk_en = 1'b0;
            end
            @(posedge clk);
            #1 clk_en = 1'b1;
        end
    end

    a_frame_sum: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid && armed |-> left == exp_l && right == exp_r)
        else begin
            $display("MISMATCH t=%0t left %0d right %0d, expected %0d %0d",
                     $time, left, right, exp_l, exp_r);
            errors++;
        end

    a_out_held: assert property (@(posedge clk) disable iff (!arst_n)
        ($changed(left) || $changed(right)) |-> sample_valid)
        else begin
            $display("Outputs changed without a sample_valid pulse at %0t", $time);
            errors++;
            pulse_errors++;
        end

    a_pulse_width: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid |=> !sample_valid)
        else begin
            $display("sample_valid held longer than one cycle at %0t", $time);
            errors++;
            pulse_errors++;
        end

    // Pulse spacing and compare count
    always @(posedge clk) begin
        if (arst_n) begin
            if (clk_en) en_cnt++;
            if (sample_valid) begin
                if (pulses > 0) begin
                    assert (en_cnt == num_slots) else begin
                        $display("MISMATCH t=%0t %0d clk_en cycles between pulses, expected %0d",
                                 $time, en_cnt, num_slots);
                        errors++;
                        pulse_errors++;
                    end
                end
                pulses++;
                en_cnt = 0;
            end
            if (sample_valid && armed) checks++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout, test sequence still running after %0d cycles", max_cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // Operators that reach the output for each algorithm
    function automatic bit routed(input int alg, input int op);
        if (alg <= 3) return op == 3;
        if (alg == 4) return op == 1 || op == 3;
        if (alg <= 6) return op != 0;
        return 1'b1;
    endfunction

    // One side of a frame from the shadow config and ADPCM inputs
    function automatic int expected_sum(input bit left_side);
        int          sum, ch, lvl, alg, pos, op;
        logic [1:0]  rl;
        logic [15:0] cw;
        sum = 0;
        for (pos = 0; pos < 6; pos++) begin
            ch  = (pos < 3) ? pos : pos + 1;    // Code 3 unused
            cw  = shadow[chan_cfg_base + pos];
            alg = int'(cw[2:0]);
            rl  = cw[4:3];
            for (op = 0; op < 4; op++) begin
                lvl = int'($signed(shadow[pos * 4 + op][13:0]));
                if (op == 0 && ch == 2)
                    sum += (left_side ? int'(adpcm_a_l) : int'(adpcm_a_r)) * 8;
                else if (op == 0 && ch == 6)
                    sum += (left_side ? int'(adpcm_b_l) : int'(adpcm_b_r)) >>> 3;
                else if (routed(alg, op) && (left_side ? rl[1] : rl[0]))
                    sum += lvl;
            end
        end
        if (sum > 32767) return 32767;
        if (sum < -32768) return -32768;
        return sum;
    endfunction

    task automatic apb_transfer(input bit write, input int word, input logic [15:0] wdata,
                                output logic [15:0] rdata);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = 7'(word * 4);     // Byte address
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < 16) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        if (!pready) begin
            $display("APB transfer to word %0d did not complete by %0t", word, $time);
            errors++;
        end else if (pslverr) begin
            $display("APB transfer to word %0d got an error response at %0t", word, $time);
            errors++;
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input int word, input logic [15:0] data);
        logic [15:0] unused;
        apb_transfer(1'b1, word, data, unused);
        shadow[word] = data;
    endtask

    task automatic apb_read_check(input int word);
        logic [15:0] rd;
        apb_transfer(1'b0, word, 16'h0000, rd);
        assert (rd == shadow[word]) else begin
            $display("MISMATCH t=%0t word %0d read %h, expected %h",
                     $time, word, rd, shadow[word]);
            errors++;
        end
    endtask

    task automatic write_chan(input int pos, input int alg, input int rl);
        apb_write(chan_cfg_base + pos, 16'((rl << 3) | alg));
    endtask

    // Two frames to flush the pipeline, then one compared frame
    task automatic check_next_frame();
        int checks_before;
        checks_before = checks;
        wait_pulse();
        wait_pulse();
        @(posedge clk);
        #1;
        exp_l = expected_sum(1'b1);
        exp_r = expected_sum(1'b0);
        armed = 1'b1;
        wait_pulse();
        @(posedge clk);
        #1 armed = 1'b0;
        if (checks == checks_before) begin
            $display("Frame result was never compared, at %0t", $time);
            errors++;
        end
    endtask

    task automatic wait_pulse();
        do @(negedge clk); while (!sample_valid);
    endtask

    task automatic report_test(input string name, input int err_mark);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == err_mark) ? "passed" : "failed", errors - err_mark);
    endtask

    initial begin
        int err_mark;
        int idx;
        void'($urandom(19759));
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        adpcm_a_l = '0;
        adpcm_a_r = '0;
        adpcm_b_l = '0;
        adpcm_b_r = '0;
        armed     = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;

        // Idle outputs until the first frame pulse
        err_mark = errors;
        @(negedge clk);
        while (!sample_valid) begin
            assert (left == 0 && right == 0 && !pready) else begin
                $display("Outputs or pready not at reset values at %0t", $time);
                errors++;
            end
            @(negedge clk);
        end
        report_test("reset state", err_mark);

        err_mark = errors;
        for (idx = 0; idx < 30; idx++)
            apb_write(idx, (idx < 24) ? 16'(rand_range(-4095, 4095)) : 16'($urandom));
        for (idx = 29; idx >= 0; idx--)
            apb_read_check(idx);
        report_test("register readback", err_mark);

        // Algorithms 0..5, then 6,7,0..3
        err_mark = errors;
        for (idx = 0; idx < 6; idx++) write_chan(idx, idx, 3);
        check_next_frame();
        for (idx = 0; idx < 6; idx++) write_chan(idx, (idx + 6) % 8, 3);
        check_next_frame();
        report_test("algorithm routing", err_mark);

        err_mark = errors;
        for (idx = 0; idx < 6; idx++) write_chan(idx, 7, 2 - (idx % 3));   // rl 2,1,0
        check_next_frame();
        report_test("panning", err_mark);

        // Op 0 levels of channels 2 and 6 must not show up
        err_mark = errors;
        apb_write(8, 16'h0fff);
        apb_write(20, 16'h0fff);
        for (idx = 0; idx < 6; idx++) begin
            if (idx == 2)      write_chan(idx, 7, 0);
            else if (idx == 5) write_chan(idx, 7, 3);
            else               write_chan(idx, 0, 3);
        end
        @(posedge clk);
        #1;
        adpcm_a_l = 16'(rand_range(-4000, 4000));
        adpcm_a_r = 16'(rand_range(-4000, 4000));
        adpcm_b_l = 16'($urandom);
        adpcm_b_r = 16'($urandom);
        check_next_frame();
        report_test("adpcm substitution", err_mark);

        // Channels 0..2 full positive on left, 4..6 full negative on right
        err_mark = errors;
        adpcm_a_l = '0;
        adpcm_a_r = '0;
        adpcm_b_l = '0;
        adpcm_b_r = '0;
        for (idx = 0; idx < 24; idx++) apb_write(idx, (idx < 12) ? 16'h1fff : 16'h2000);
        for (idx = 0; idx < 6; idx++) write_chan(idx, 7, (idx < 3) ? 2 : 1);
        check_next_frame();
        report_test("saturation", err_mark);

        tests++;
        $display("test %0d frame pulse: %s, %0d pulses, %0d errors", tests,
                 (pulse_errors == 0) ? "passed" : "failed", pulses, pulse_errors);
        $display("tests %0d, frame checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/fm_mix_pkg.sv
logic/apb_cfg_slave.sv
logic/cfg_mem_arbiter.sv
logic/slot_counter.sv
logic/op_level_fetch.sv
logic/sample_acc.sv
logic/fm_out_acc.sv
logic/fm_mix_top.sv
verif/fm_mix_tb.sv

//--- Makefile
# Verilator build and run of the FM output mixer testbench
TOP := fm_mix_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
